// File: music_pkg.sv
package music_pkg;

    //------------------------------------------------------------------------
    // Types with a meaning of their own
    //------------------------------------------------------------------------

    typedef logic [15:0] sample_t;  // One audio sample
    typedef logic [19:0] period_t;  // Clock cycles between crossings
    typedef logic [11:0] note_t;    // One-hot semitone, C is the MSB
    typedef logic [ 3:0] step_t;    // Melody step index

    localparam int n_notes    = 12;
    localparam int n_melodies = 3;
    localparam int melody_len = 15;

    localparam step_t   step_recognized  = 4'd15;
    localparam sample_t sample_threshold = 16'h1100;

    //------------------------------------------------------------------------
    // One-hot semitones
    //------------------------------------------------------------------------

    localparam note_t no_note = 12'b0000_0000_0000;

    localparam note_t note_c  = 12'b1000_0000_0000;
    localparam note_t note_cs = 12'b0100_0000_0000;
    localparam note_t note_d  = 12'b0010_0000_0000;
    localparam note_t note_ds = 12'b0001_0000_0000;  // Also Eb
    localparam note_t note_e  = 12'b0000_1000_0000;
    localparam note_t note_f  = 12'b0000_0100_0000;
    localparam note_t note_fs = 12'b0000_0010_0000;
    localparam note_t note_g  = 12'b0000_0001_0000;
    localparam note_t note_gs = 12'b0000_0000_1000;  // Also Ab
    localparam note_t note_a  = 12'b0000_0000_0100;
    localparam note_t note_as = 12'b0000_0000_0010;  // Also Bb
    localparam note_t note_b  = 12'b0000_0000_0001;

    // Lowest octave accepted, in hundredths of a hertz, C first
    localparam logic [18:0] freq_100_table [0:n_notes - 1] = '{
        19'd26163, 19'd27718, 19'd29366, 19'd31113,
        19'd32963, 19'd34923, 19'd36999, 19'd39200,
        19'd41530, 19'd44000, 19'd46616, 19'd49388
    };

    //------------------------------------------------------------------------
    // Tunes
    //------------------------------------------------------------------------

    localparam note_t melody_table [0:n_melodies - 1][0:melody_len - 1] = '{
        // Tune 0
        '{
            note_as, note_d,  note_as, note_d,  note_ds,
            note_d,  note_c,  note_a,  note_c,  note_a,
            note_c,  note_d,  note_c,  note_as, note_g
        },
        // Tune 1
        '{
            note_g,  note_c,  note_ds, note_d,  note_c,
            note_ds, note_c,  note_d,  note_c,  note_gs,
            note_as, note_g,  note_c,  note_ds, note_d
        },
        // Tune 2
        '{
            note_e,  note_f,  note_e,  note_a,  note_b,
            note_c,  note_d,  note_c,  note_b,  note_c,
            note_g,  note_c,  note_a,  note_c,  note_a
        }
    };

endpackage

// File: period_meter.sv
module period_meter
    import music_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  sample_t i_sample,
    output period_t o_distance
);

    localparam period_t period_max = '1;  // Saturation value

    sample_t prev_sample;
    period_t count;
    logic    crossing;

    // Rising edge through the threshold
    assign crossing = (i_sample >= sample_threshold)
                   && (prev_sample < sample_threshold);

    //------------------------------------------------------------------------
    // Cycle count between crossings
    //------------------------------------------------------------------------

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prev_sample <= '0;
            count       <= '0;
            o_distance  <= '0;
        end
        else
        begin
            prev_sample <= i_sample;

            if (crossing)
            begin
                o_distance <= count;
                count      <= '0;
            end
            else if (count != period_max)  // Hold at the top
            begin
                count <= count + period_t'(1);
            end
        end
    end

endmodule

// File: note_classifier.sv
module note_classifier
    import music_pkg::*;
#(
    parameter int clk_hz = 50_000_000
)
(
    input  period_t i_distance,
    output note_t   o_note
);

    localparam int n_octaves = 3;  // Multipliers 1, 2 and 4

    // Wide enough for clk_hz times 102 without overflow
    typedef logic [63:0] bound_t;

    localparam bound_t clk_wide = bound_t'(clk_hz);

    bound_t distance_wide;

    assign distance_wide = bound_t'(i_distance);

    //------------------------------------------------------------------------
    // Band match per semitone and octave
    //------------------------------------------------------------------------

    for (genvar i = 0; i < n_notes; i++)
    begin : g_note
        logic [n_octaves - 1:0] band_hit;

        for (genvar j = 0; j < n_octaves; j++)
        begin : g_octave
            // Frequency scaled by the octave multiplier
            localparam bound_t freq_scaled = bound_t'(freq_100_table[i]) << j;

            // Multiply first so small clocks keep their precision
            localparam bound_t low_bound  = clk_wide * 98  / freq_scaled;
            localparam bound_t high_bound = clk_wide * 102 / freq_scaled;

            assign band_hit[j] = (distance_wide > low_bound)
                              && (distance_wide < high_bound);
        end

        // C sits at the top bit
        assign o_note[n_notes - 1 - i] = |band_hit;
    end

endmodule

// File: note_filter.sv
module note_filter
    import music_pkg::*;
#(
    parameter int w_stable = 18
)
(
    input  logic  clk,
    input  logic  reset,
    input  note_t i_note,
    output note_t o_note
);

    note_t               d_note;      // Raw note, one cycle late
    logic [w_stable-1:0] stable_cnt;  // Cycles without a change

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            d_note <= no_note;
        else
            d_note <= i_note;
    end

    //------------------------------------------------------------------------
    // Stability window
    //------------------------------------------------------------------------

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            stable_cnt <= '0;
        else if (i_note == d_note)
            stable_cnt <= stable_cnt + 1'b1;
        else
            stable_cnt <= '0;  // Any change restarts the wait
    end

    // Accept the note once the window has run out
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            o_note <= no_note;
        else if (&stable_cnt)
            o_note <= d_note;
    end

endmodule

// File: melody_tracker.sv
module melody_tracker
    import music_pkg::*;
#(
    parameter int melody_index = 0
)
(
    input  logic  clk,
    input  logic  reset,
    input  note_t i_note,
    output step_t o_step
);

    logic done;
    note_t expected;  // Note wanted at the current step

    assign done = (o_step == step_recognized);

    // No note can match once the tune is done
    assign expected = done ? no_note : melody_table[melody_index][o_step];

    //------------------------------------------------------------------------
    // Step counter
    //------------------------------------------------------------------------

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            o_step <= '0;
        end
        else if (!done && i_note == expected)
        begin
            o_step <= o_step + step_t'(1);  // Wrong notes leave it alone
        end
    end

endmodule

// File: melody_recognizer.sv
module melody_recognizer
    import music_pkg::*;
#(
    parameter int clk_hz   = 50_000_000,
    parameter int w_stable = 18
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  sample_t                 i_sample,
    output note_t                   o_note,
    output logic [n_melodies - 1:0] o_recognized,
    output logic                    o_all_recognized
);

    period_t distance;
    note_t   raw_note;
    note_t   filt_note;

    step_t                   steps [0:n_melodies - 1];
    logic [n_melodies - 1:0] tune_done;

    //------------------------------------------------------------------------
    // Pitch path
    //------------------------------------------------------------------------

    period_meter u_period_meter
    (
        .clk        ( clk      ),
        .reset      ( reset    ),
        .i_sample   ( i_sample ),
        .o_distance ( distance )
    );

    note_classifier #( .clk_hz ( clk_hz ) ) u_note_classifier
    (
        .i_distance ( distance ),
        .o_note     ( raw_note )
    );

    note_filter #( .w_stable ( w_stable ) ) u_note_filter
    (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .i_note ( raw_note  ),
        .o_note ( filt_note )
    );

    assign o_note = filt_note;

    //------------------------------------------------------------------------
    // One tracker per tune
    //------------------------------------------------------------------------

    for (genvar k = 0; k < n_melodies; k++)
    begin : g_tracker
        melody_tracker #( .melody_index ( k ) ) u_melody_tracker
        (
            .clk    ( clk       ),
            .reset  ( reset     ),
            .i_note ( filt_note ),
            .o_step ( steps[k]  )
        );

        assign tune_done[k] = (steps[k] == step_recognized);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            o_recognized     <= '0;
            o_all_recognized <= 1'b0;
        end
        else
        begin
            o_recognized     <= tune_done;
            o_all_recognized <= &tune_done;  // Every tune heard
        end
    end

endmodule

// File: tb_checker.sv
module tb_checker
    import music_pkg::*;
#(
    parameter int clk_hz = 1_000_000
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  note_t                   i_note,
    input  logic [n_melodies - 1:0] i_recognized,
    input  logic                    i_all_recognized,
    input  period_t                 i_tone_period,
    input  int                      i_tone_id,
    input  logic                    i_check_req,
    input  logic [n_melodies - 1:0] i_check_flags,
    output int                      o_error_count,
    output int                      o_check_count
);

    timeunit 1ns;
    timeprecision 100ps;

    int                      error_count = 0;
    int                      check_count = 0;
    int                      seen_id;
    int                      settle_cnt;
    int                      settle_limit;
    logic                    settling;
    note_t                   cur_note;   // Expected for the tone now playing
    note_t                   prev_note;  // Expected for the tone before
    note_t                   last_note;
    int                      model_step [0:n_melodies - 1];
    logic [n_melodies - 1:0] flags_d1;
    logic [n_melodies - 1:0] flags_d2;

    assign o_error_count = error_count;
    assign o_check_count = check_count;

    // Band rule, 98 to 102 percent over three octaves
    function automatic note_t classify_period(input period_t p);
        note_t  n;
        longint f;
        n = no_note;
        for (int i = 0; i < n_notes; i++)
        begin
            for (int m = 1; m <= 4; m = m * 2)
            begin
                f = longint'(freq_100_table[i]) * longint'(m);
                if (longint'(p) > longint'(clk_hz) * 98 / f
                    && longint'(p) < longint'(clk_hz) * 102 / f)
                    n[n_notes - 1 - i] = 1'b1;
            end
        end
        return n;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("ERROR %0d ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    //--------------------------------------------------------------------------
    // Sampled at the falling edge, away from all updates
    //--------------------------------------------------------------------------

    always @(negedge clk)
    begin
        if (reset)
        begin
            compare_value("o_note in reset", 32'(i_note), 32'(no_note));
            compare_value("o_recognized in reset", 32'(i_recognized), 32'd0);
            compare_value("o_all_recognized in reset", 32'(i_all_recognized), 32'd0);
            for (int k = 0; k < n_melodies; k++)
                model_step[k] = 0;
            flags_d1  = '0;
            flags_d2  = '0;
            last_note = no_note;
            cur_note  = no_note;
            prev_note = no_note;
            settling  = 1'b0;
            seen_id   = i_tone_id;
        end
        else
        begin
            if (i_tone_id != seen_id)  // New tone started
            begin
                seen_id      = i_tone_id;
                prev_note    = cur_note;
                cur_note     = classify_period(i_tone_period);
                settling     = 1'b1;
                settle_cnt   = 0;
                settle_limit = 4 * int'(i_tone_period) + 300;
            end

            if (i_note != cur_note && i_note != prev_note && i_note != no_note)
            begin
                $display("ERROR %0d ns: o_note %h is neither %h nor %h", $time,
                         i_note, cur_note, prev_note);
                error_count++;
            end

            if (settling && i_note == cur_note)
            begin
                settling = 1'b0;
                check_count++;
            end
            else if (settling)
            begin
                settle_cnt++;
                if (settle_cnt > settle_limit)
                begin
                    $display("Timeout: o_note did not settle to %h within %0d cycles (%0d ns)",
                             cur_note, settle_limit, $time);
                    error_count++;
                    settling = 1'b0;
                end
            end

            // Trackers step on each new filtered note
            if (i_note != last_note)
            begin
                last_note = i_note;
                for (int k = 0; k < n_melodies; k++)
                    if (model_step[k] < melody_len)
                        if (i_note == melody_table[k][model_step[k]])
                            model_step[k]++;
            end

            compare_value("o_recognized", 32'(i_recognized), 32'(flags_d2));
            compare_value("o_all_recognized", 32'(i_all_recognized), 32'(&flags_d2));
            flags_d2 = flags_d1;  // Tracker register, then flag register
            for (int k = 0; k < n_melodies; k++)
                flags_d1[k] = (model_step[k] == melody_len);

            if (i_check_req)
                compare_value("o_recognized at tune end", 32'(i_recognized),
                              32'(i_check_flags));
        end
    end

endmodule

// File: tb_melody.sv
module tb_melody
    import music_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_hz       = 1_000_000;
    localparam int w_stable     = 8;
    localparam int tone_periods = 6;

    logic                    clk = 1'b0;
    logic                    reset;
    sample_t                 sample;
    note_t                   filt_note;
    logic [n_melodies - 1:0] recognized;
    logic                    all_recognized;
    period_t                 tone_period;  // Zero while silent
    int                      tone_id;      // Bumped at each new tone
    logic                    check_req;
    logic [n_melodies - 1:0] check_flags;
    int                      error_count;
    int                      check_count;
    logic [31:0]             lfsr_state;

    always #20 clk = ~clk;

    melody_recognizer #( .clk_hz ( clk_hz ), .w_stable ( w_stable ) ) DUT
    (
        .clk              ( clk            ),
        .reset            ( reset          ),
        .i_sample         ( sample         ),
        .o_note           ( filt_note      ),
        .o_recognized     ( recognized     ),
        .o_all_recognized ( all_recognized )
    );

    tb_checker #( .clk_hz ( clk_hz ) ) u_checker
    (
        .clk              ( clk            ),
        .reset            ( reset          ),
        .i_note           ( filt_note      ),
        .i_recognized     ( recognized     ),
        .i_all_recognized ( all_recognized ),
        .i_tone_period    ( tone_period    ),
        .i_tone_id        ( tone_id        ),
        .i_check_req      ( check_req      ),
        .i_check_flags    ( check_flags    ),
        .o_error_count    ( error_count    ),
        .o_check_count    ( check_count    )
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic pick_mult(output int m);
        logic [31:0] r;
        take_bits(2, r);
        m = 1 << int'(r % 32'd3);
    endtask

    //--------------------------------------------------------------------------
    // Square wave with random levels on each side of the threshold
    //--------------------------------------------------------------------------

    task automatic play_tone(input int semi, input int mult, input int pct);
        longint      nominal;
        int          period;
        logic [31:0] r;
        nominal     = longint'(clk_hz) * 100
                    / (longint'(freq_100_table[semi]) * longint'(mult));
        period      = int'(nominal * longint'(pct) / 100);
        tone_period = period_t'(period);
        tone_id     = tone_id + 1;
        for (int c = 0; c < tone_periods * period; c++)
        begin
            if (c % period < period / 2)
            begin
                take_bits(16, r);
                sample = sample_t'(r) | sample_threshold;
            end
            else
            begin
                take_bits(12, r);  // Always below 16'h1100
                sample = sample_t'(r);
            end
            next_cycle();
        end
    endtask

    function automatic int note_index(input note_t n);
        for (int i = 0; i < n_notes; i++)
            if (n[n_notes - 1 - i])
                return i;
        return 0;
    endfunction

    task automatic play_tune(input int k, input logic with_wrong);
        int          idx;
        int          w;
        int          m;
        logic [31:0] r;
        for (int s = 0; s < melody_len; s++)
        begin
            idx = note_index(melody_table[k][s]);
            take_bits(1, r);
            if (with_wrong && r[0])
            begin
                take_bits(4, r);
                w = int'(r % 32'd12);
                if (w == idx)
                    w = (w + 1) % n_notes;
                pick_mult(m);
                play_tone(w, m, 100);
            end
            pick_mult(m);
            play_tone(idx, m, 100);
        end
    endtask

    task automatic request_check(input logic [n_melodies - 1:0] flags);
        check_flags = flags;
        check_req   = 1'b1;
        next_cycle();
        check_req   = 1'b0;
    endtask

    task automatic apply_reset();
        reset       = 1'b1;
        sample      = '0;
        tone_period = '0;
        repeat (10) next_cycle();
        reset       = 1'b0;
    endtask

    initial
    begin
        int          order [0:3 * n_notes - 1];
        int          j;
        int          tmp;
        int          m;
        logic [31:0] r;
        tone_id     = 0;
        check_req   = 1'b0;
        check_flags = '0;
        lfsr_state  = 32'h32c700f7;
        apply_reset();

        // Every semitone in three octaves, shuffled
        for (int i = 0; i < 3 * n_notes; i++)
            order[i] = i;
        for (int i = 3 * n_notes - 1; i > 0; i--)
        begin
            take_bits(6, r);
            j        = int'(r % 32'(i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 3 * n_notes; i++)
            play_tone(order[i] % n_notes, 1 << (order[i] / n_notes), 100);

        play_tone(0, 1, 105);  // Below the lowest band
        play_tone(11, 4, 95);  // Above the highest band

        play_tune(0, 1'b1);
        request_check(3'b001);
        play_tune(1, 1'b0);
        request_check(3'b011);
        play_tune(2, 1'b0);
        request_check(3'b111);
        for (int i = 0; i < 5; i++)
        begin
            take_bits(4, r);
            pick_mult(m);
            play_tone(int'(r % 32'd12), m, 100);
        end
        request_check(3'b111);

        apply_reset();
        play_tune(2, 1'b0);
        request_check(3'b100);
        repeat (20) next_cycle();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: all.f
music_pkg.sv
period_meter.sv
note_classifier.sv
note_filter.sv
melody_tracker.sv
melody_recognizer.sv
tb_checker.sv
tb_melody.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_melody -f all.f \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vtb_melody)
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
